//--- fpu_testdata.txt
# op mode operand_a operand_b expected_result expected_flags, all hex
# op: 0 add, 1 sub, 2 mul   mode: 0 nearest, 1 to zero, 2 to +inf, 3 to -inf
0 0 3f800000 40000000 40400000 00
1 0 40400000 3f800000 40000000 00
0 1 3fc00000 3fc00000 40400000 00
1 0 40400000 40400000 00000000 10
0 0 3f800000 33800000 3f800000 20
0 1 3f800000 33800000 3f800000 20
0 2 3f800000 33800000 3f800001 20
0 3 bf800000 b3800000 bf800001 20
0 0 3f800000 33c00000 3f800001 20
1 0 3f800000 33000000 3f800000 20
1 1 3f800000 33000000 3f7fffff 20
0 2 bfc00000 bfc00000 c0400000 00
2 0 40000000 40400000 40c00000 00
2 3 3fc00000 3fc00000 40100000 00
2 0 3f800001 3f800001 3f800002 20
2 2 3f800001 3f800001 3f800003 20
2 1 3f800001 3f800001 3f800002 20
2 0 7f000000 40000000 7f800000 a1
2 0 00800000 00800000 00000000 32
2 0 00800000 3f000000 00400000 00
1 0 7f800000 7f800000 7fbfffff 44
2 0 00000000 7f800000 7fbfffff 44
0 0 7fc00000 3f800000 7fc00000 08
2 0 7f800000 40000000 7f800000 80
2 0 ff800000 40000000 ff800000 80
0 0 7f800000 7f800000 7f800000 80

//--- flist.f
fpu_types_pkg.sv
fpu_ctrl_pkg.sv
fpu_addsub.sv
fpu_mul.sv
fpu_rnd.sv
fpu_top.sv
fpu_checker.sv
tb_fpu.sv

//--- Makefile
# Verilator build and run of the FPU testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary -Wno-fatal
TOP       ?= tb_fpu
OBJ_DIR   ?= obj_dir
FLIST     ?= flist.f

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

# fails unless the pass line shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '\*\* PASS \*\*'

clean:
	rm -rf $(OBJ_DIR)

//--- tb_fpu.sv
`timescale 1ns/1ps

module tb_fpu
  import fpu_ctrl_pkg::*;
();

  localparam int max_vec     = 64;
  localparam int drain_limit = 60;  // cycles per drain wait

  logic               clk, rst, start, adv, flush, done;
  logic [1:0]         op, rmode;
  logic [31:0]        a, b, result, exp_res;
  logic               valid;
  logic [flags_w-1:0] flags, exp_flg;
  logic [15:0]        exp_id, pending, errors;
  logic               timed_out;

  // vector table
  logic [1:0]         v_op[max_vec];
  logic [1:0]         v_mode[max_vec];
  logic [31:0]        v_a[max_vec], v_b[max_vec], v_res[max_vec];
  logic [flags_w-1:0] v_flg[max_vec];
  int                 n_vec;

  always #10 clk = ~clk;  // 20 ns

  fpu_top u_fpu_top (
    .clk, .rst, .start_i(start), .op_i(op), .rmode_i(rmode), .a_i(a), .b_i(b),
    .adv_i(adv), .flush_i(flush), .result_o(result), .valid_o(valid), .flags_o(flags)
  );

  fpu_checker u_checker (
    .clk, .rst, .adv_i(adv), .flush_i(flush), .start_i(start),
    .exp_result_i(exp_res), .exp_flags_i(exp_flg), .exp_id_i(exp_id),
    .result_i(result), .valid_i(valid), .flags_i(flags), .done_i(done),
    .pending_o(pending), .errors_o(errors)
  );

  //////////////////////////////
  // helpers

  task automatic load_vectors();
    int    fd, code, n;
    int    f_op, f_md, f_flg;
    int    f_a, f_b, f_res;
    string line;
    n_vec = 0;
    fd = $fopen("fpu_testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open fpu_testdata.txt");
      return;
    end
    while (!$feof(fd) && n_vec < max_vec) begin
      code = $fgets(line, fd);
      if (code == 0 || line.len() < 2 || line.getc(0) == "#") continue;  // skip comment lines
      n = $sscanf(line, "%h %h %h %h %h %h", f_op, f_md, f_a, f_b, f_res, f_flg);
      if (n == 6) begin
        v_op[n_vec]   = 2'(f_op);
        v_mode[n_vec] = 2'(f_md);
        v_a[n_vec]    = 32'(f_a);
        v_b[n_vec]    = 32'(f_b);
        v_res[n_vec]  = 32'(f_res);
        v_flg[n_vec]  = flags_w'(f_flg);
        n_vec++;
      end
    end
    $fclose(fd);
  endtask

  // index of the first vector with this operation
  function automatic int first_of_op(input logic [1:0] o);
    for (int k = 0; k < n_vec; k++) begin
      if (v_op[k] == o) return k;
    end
    return 0;
  endfunction

  task automatic drive_vec(input int k);  // call right after a falling edge
    start   = 1'b1;
    op      = v_op[k];
    rmode   = v_mode[k];
    a       = v_a[k];
    b       = v_b[k];
    exp_res = v_res[k];
    exp_flg = v_flg[k];
    exp_id  = 16'(k);
  endtask

  task automatic wait_drain(input string what);
    int t;
    for (t = 0; t < drain_limit && pending != 0; t++) @(negedge clk);
    if (pending != 0) begin
      $display("timeout: missing result in %s, %0d operations never came back", what,
               pending);
      timed_out = 1'b1;
    end
  endtask

  task automatic send_singles(input int first, input int last);
    for (int k = first; k < last && !timed_out; k++) begin
      @(negedge clk);
      adv = 1'b1;
      drive_vec(k);
      @(negedge clk);
      start = 1'b0;
      wait_drain("single vector");
    end
  endtask

  // one start per cycle in nearest mode because rmode_i is a shared level
  task automatic stream_vectors();
    for (int k = 0; k < n_vec; k++) begin
      if (v_mode[k] != rm_nearest) continue;
      @(negedge clk);
      adv = 1'b1;
      drive_vec(k);
    end
    @(negedge clk);
    start = 1'b0;
    wait_drain("back-to-back stream");
  endtask

  task automatic stall_stream();
    int g;
    for (int k = 0; k < n_vec; k++) begin
      if (v_mode[k] != rm_nearest) continue;
      g = int'($urandom % 3);
      for (int i = 0; i < g; i++) begin  // stall cycles
        @(negedge clk);
        start = 1'b0;
        adv   = 1'b0;
        a     = ~a;  // frozen unit must ignore new operands
        b     = ~b;
      end
      @(negedge clk);
      adv = 1'b1;
      drive_vec(k);
    end
    for (int i = 0; i < 8; i++) begin  // random stalls while draining
      @(negedge clk);
      start = 1'b0;
      adv   = 1'($urandom % 2);
    end
    @(negedge clk);
    adv = 1'b1;
    wait_drain("stalled stream");
  endtask

  // flush edge meets two older operations and one new start
  task automatic flush_in_flight(input int k_old, input int k_new);
    @(negedge clk);
    adv = 1'b1;
    drive_vec(k_old);
    @(negedge clk);
    drive_vec(k_old);
    @(negedge clk);
    drive_vec(k_new);
    flush = 1'b1;  // older two in rounding, newest in its own unit
    @(negedge clk);
    start = 1'b0;
    flush = 1'b0;
    repeat (6) @(negedge clk);  // nothing may come back
  endtask

  //////////////////////////////
  // main sequence

  initial begin
    clk       = 1'b0;
    rst       = 1'b1;
    start     = 1'b0;
    op        = op_add;
    rmode     = rm_nearest;
    a         = '0;
    b         = '0;
    adv       = 1'b1;
    flush     = 1'b0;
    done      = 1'b0;
    exp_res   = '0;
    exp_flg   = '0;
    exp_id    = '0;
    timed_out = 1'b0;
    void'($urandom(32'h76e8));
    load_vectors();
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    if (n_vec == 0) begin
      $display("no test vectors were read");
      timed_out = 1'b1;
    end
    if (!timed_out) send_singles(0, n_vec);
    if (!timed_out) stream_vectors();
    if (!timed_out) stall_stream();
    if (!timed_out) begin
      flush_in_flight(first_of_op(op_add), first_of_op(op_mul));
      flush_in_flight(first_of_op(op_mul), first_of_op(op_add));
      send_singles(0, 3);  // normal vectors after the flushes
    end
    @(negedge clk);
    done = 1'b1;
    #1;
    if (timed_out || errors != 0) begin
      $display("** FAIL **");
    end else begin
      $display("** PASS **");
    end
    $finish;
  end

endmodule

//--- fpu_checker.sv
`timescale 1ns/1ps

module fpu_checker
  import fpu_types_pkg::*, fpu_ctrl_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic               adv_i,
  input  logic               flush_i,
  input  logic               start_i,
  input  logic [31:0]        exp_result_i,  // expected values, valid with start_i
  input  logic [flags_w-1:0] exp_flags_i,
  input  logic [15:0]        exp_id_i,
  input  logic [31:0]        result_i,      // dut outputs
  input  logic               valid_i,
  input  logic [flags_w-1:0] flags_i,
  input  logic               done_i,
  output logic [15:0]        pending_o,
  output logic [15:0]        errors_o
);

  // in-flight expectations, oldest first
  logic [31:0]        q_res[$];
  logic [flags_w-1:0] q_flg[$];
  int                 q_id[$];
  int                 q_due[$];

  int                 adv_cnt;   // advancing edges seen
  int                 n_pass, n_fail, n_other;
  logic               held;      // last edge had the pipe frozen
  logic [31:0]        prev_res, e_res;
  logic               prev_valid;
  logic [flags_w-1:0] prev_flags, e_flg;
  int                 e_id, e_due;

  function automatic string special_name(input logic [31:0] w);
    if (w[30:0] == f32_inf) return " (inf)";
    if (w[30:0] == f32_qnan) return " (qnan)";
    if (w[30:0] == f32_snan) return " (invalid nan)";
    return "";
  endfunction

  //////////////////////////////
  // compare on every rising edge

  always @(posedge clk) begin
    if (rst) begin
      adv_cnt = 0;
      held    = 1'b0;
      q_res.delete();
      q_flg.delete();
      q_id.delete();
      q_due.delete();
    end else begin
      // frozen pipe must hold its outputs
      if (held && (result_i !== prev_res || valid_i !== prev_valid || flags_i !== prev_flags))
      begin
        $display("[FAIL] %0t ns: outputs changed while adv_i was low", $time);
        n_other++;
      end
      if (adv_i && valid_i) begin  // result taken on this edge
        if (q_res.size() == 0) begin
          $display("unexpected result %h at %0t ns with no operation in flight",
                   result_i, $time);
          n_other++;
        end else begin
          e_res = q_res.pop_front();
          e_flg = q_flg.pop_front();
          e_id  = q_id.pop_front();
          e_due = q_due.pop_front();
          if (result_i === e_res && flags_i === e_flg && adv_cnt == e_due) begin
            $display("test %0d ok: %h flags %h", e_id, result_i, flags_i);
            n_pass++;
          end else begin
            $display("[FAIL] %0t ns: test %0d got %h flags %h, expected %h%s flags %h, %s",
                     $time, e_id, result_i, flags_i, e_res, special_name(e_res), e_flg,
                     (adv_cnt == e_due) ? "latency ok" : "wrong latency");
            n_fail++;
          end
        end
      end
      if (flush_i) begin  // everything in flight is dropped
        q_res.delete();
        q_flg.delete();
        q_id.delete();
        q_due.delete();
      end else if (adv_i && start_i) begin
        q_res.push_back(exp_result_i);
        q_flg.push_back(exp_flags_i);
        q_id.push_back(int'(exp_id_i));
        q_due.push_back(adv_cnt + 3);  // 1 unit + 2 rounding stages
      end
      if (adv_i) adv_cnt++;
      held = ~adv_i & ~flush_i;
    end
    prev_res   = result_i;
    prev_valid = valid_i;
    prev_flags = flags_i;
    pending_o  = 16'(q_res.size());
    errors_o   = 16'(n_fail + n_other);
  end

  always @(posedge done_i) begin
    $display("tests: %0d passed, %0d failed, %0d other errors", n_pass, n_fail, n_other);
  end

endmodule

//--- fpu_top.sv
`timescale 1ns/1ps

module fpu_top
  import fpu_types_pkg::*, fpu_ctrl_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic               start_i,   // one-cycle strobe
  input  logic [1:0]         op_i,
  input  logic [1:0]         rmode_i,
  input  logic [31:0]        a_i,
  input  logic [31:0]        b_i,
  input  logic               adv_i,     // low freezes every stage
  input  logic               flush_i,
  output logic [31:0]        result_o,
  output logic               valid_o,
  output logic [flags_w-1:0] flags_o
);

  // op decode
  logic add_start, mul_start, sub;
  assign sub       = (op_i == op_sub);
  assign add_start = start_i & ((op_i == op_add) | sub);
  assign mul_start = start_i & (op_i == op_mul);  // unused code starts nothing

  //////////////////////////////
  // unit outputs

  logic                 add_rdy, add_sign, add_inv, add_inf, add_snan, add_qnan, add_anan_sign;
  logic [exp10_w-1:0]   add_exp10;
  logic [fract24_w-1:0] add_fract24;
  logic [1:0]           add_rs;

  logic                 mul_rdy, mul_sign, mul_inv, mul_inf, mul_snan, mul_qnan, mul_anan_sign;
  logic [exp10_w-1:0]   mul_exp10;
  logic [fract24_w-1:0] mul_fract24;
  logic [1:0]           mul_rs;

  fpu_addsub u_addsub (
    .clk, .rst, .adv_i, .flush_i,
    .start_i     (add_start),
    .sub_i       (sub),
    .a_i, .b_i,
    .rdy_o       (add_rdy),
    .sign_o      (add_sign),
    .exp10_o     (add_exp10),
    .fract24_o   (add_fract24),
    .rs_o        (add_rs),
    .inv_o       (add_inv),
    .inf_o       (add_inf),
    .snan_o      (add_snan),
    .qnan_o      (add_qnan),
    .anan_sign_o (add_anan_sign)
  );

  fpu_mul u_mul (
    .clk, .rst, .adv_i, .flush_i,
    .start_i     (mul_start),
    .a_i, .b_i,
    .rdy_o       (mul_rdy),
    .sign_o      (mul_sign),
    .exp10_o     (mul_exp10),
    .fract24_o   (mul_fract24),
    .rs_o        (mul_rs),
    .inv_o       (mul_inv),
    .inf_o       (mul_inf),
    .snan_o      (mul_snan),
    .qnan_o      (mul_qnan),
    .anan_sign_o (mul_anan_sign)
  );

  // shared rounding, two more stages
  fpu_rnd u_rnd (
    .clk, .rst, .adv_i, .flush_i, .rmode_i,
    .add_rdy_i       (add_rdy),
    .add_sign_i      (add_sign),
    .add_exp10_i     (add_exp10),
    .add_fract24_i   (add_fract24),
    .add_rs_i        (add_rs),
    .add_inv_i       (add_inv),
    .add_inf_i       (add_inf),
    .add_snan_i      (add_snan),
    .add_qnan_i      (add_qnan),
    .add_anan_sign_i (add_anan_sign),
    .mul_rdy_i       (mul_rdy),
    .mul_sign_i      (mul_sign),
    .mul_exp10_i     (mul_exp10),
    .mul_fract24_i   (mul_fract24),
    .mul_rs_i        (mul_rs),
    .mul_inv_i       (mul_inv),
    .mul_inf_i       (mul_inf),
    .mul_snan_i      (mul_snan),
    .mul_qnan_i      (mul_qnan),
    .mul_anan_sign_i (mul_anan_sign),
    .result_o, .valid_o, .flags_o
  );

endmodule

//--- fpu_rnd.sv
`timescale 1ns/1ps

module fpu_rnd
  import fpu_types_pkg::*, fpu_ctrl_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 adv_i,            // advance pipe
  input  logic                 flush_i,          // clear valids and outputs
  input  logic [1:0]           rmode_i,          // level, not pipelined
  // add/sub unit
  input  logic                 add_rdy_i,
  input  logic                 add_sign_i,
  input  logic [exp10_w-1:0]   add_exp10_i,
  input  logic [fract24_w-1:0] add_fract24_i,
  input  logic [1:0]           add_rs_i,
  input  logic                 add_inv_i,
  input  logic                 add_inf_i,
  input  logic                 add_snan_i,
  input  logic                 add_qnan_i,
  input  logic                 add_anan_sign_i,
  // mul unit
  input  logic                 mul_rdy_i,
  input  logic                 mul_sign_i,
  input  logic [exp10_w-1:0]   mul_exp10_i,
  input  logic [fract24_w-1:0] mul_fract24_i,
  input  logic [1:0]           mul_rs_i,
  input  logic                 mul_inv_i,
  input  logic                 mul_inf_i,
  input  logic                 mul_snan_i,
  input  logic                 mul_qnan_i,
  input  logic                 mul_anan_sign_i,
  // result
  output logic [31:0]          result_o,
  output logic                 valid_o,
  output logic [flags_w-1:0]   flags_o
);

  //////////////////////////////
  // stage 1, select and round

  logic                 s1t_sign, s1t_inv, s1t_inf, s1t_snan, s1t_qnan, s1t_anan_sign;
  logic [exp10_w-1:0]   s1t_exp10;
  logic [fract24_w-1:0] s1t_fract24;
  logic [1:0]           s1t_rs;
  logic                 s1t_lost, s1t_rnd_up;

  // add first when both claim ready
  assign {s1t_sign, s1t_exp10, s1t_fract24, s1t_rs, s1t_inv, s1t_inf, s1t_snan, s1t_qnan,
          s1t_anan_sign} =
    add_rdy_i ? {add_sign_i, add_exp10_i, add_fract24_i, add_rs_i, add_inv_i, add_inf_i,
                 add_snan_i, add_qnan_i, add_anan_sign_i} :
    mul_rdy_i ? {mul_sign_i, mul_exp10_i, mul_fract24_i, mul_rs_i, mul_inv_i, mul_inf_i,
                 mul_snan_i, mul_qnan_i, mul_anan_sign_i} : '0;

  assign s1t_lost = |s1t_rs;  // anything shifted out

  always_comb begin
    case (rmode_i)
      rm_nearest: s1t_rnd_up = s1t_rs[1] & (s1t_rs[0] | s1t_fract24[0]);  // tie -> even
      rm_to_zero: s1t_rnd_up = 1'b0;                                       // truncate
      rm_to_infp: s1t_rnd_up = ~s1t_sign & s1t_lost;
      rm_to_infm: s1t_rnd_up = s1t_sign & s1t_lost;
    endcase
  end

  logic                 s1o_ready;
  logic                 s1o_sign, s1o_lost, s1o_inv, s1o_inf, s1o_snan, s1o_qnan;
  logic                 s1o_anan_sign;
  logic [exp10_w-1:0]   s1o_exp10;
  logic [fract24_w:0]   s1o_fract25;  // extra msb catches round carry

  always_ff @(posedge clk) begin
    if (adv_i) begin
      s1o_sign      <= s1t_sign;
      s1o_exp10     <= s1t_exp10;
      s1o_fract25   <= {1'b0, s1t_fract24} + {{fract24_w{1'b0}}, s1t_rnd_up};
      s1o_lost      <= s1t_lost;
      s1o_inv       <= s1t_inv;
      s1o_inf       <= s1t_inf;
      s1o_snan      <= s1t_snan;
      s1o_qnan      <= s1t_qnan;
      s1o_anan_sign <= s1t_anan_sign;
    end
  end

  always_ff @(posedge clk) begin
    if (rst | flush_i) begin
      s1o_ready <= 1'b0;
    end else if (adv_i) begin
      s1o_ready <= add_rdy_i | mul_rdy_i;
    end
  end

  //////////////////////////////
  // stage 2, renormalize and pack

  logic                 s2t_shr, s2t_dn, s2t_00;
  logic [exp10_w-1:0]   s2t_exp10;
  logic [fract24_w-1:0] s2t_fract24;
  f32_word_u            s2t_word;  // finite result
  logic [31:0]          s2t_res;
  logic                 s2t_ine, s2t_ovf, s2t_inf, s2t_unf, s2t_zer;

  assign s2t_shr     = s1o_fract25[fract24_w];  // 1.11..1 rounded up to 10.0
  assign s2t_exp10   = s1o_exp10 + {{(exp10_w-1){1'b0}}, s2t_shr};
  assign s2t_fract24 = s2t_shr ? s1o_fract25[fract24_w:1] : s1o_fract25[fract24_w-1:0];
  assign s2t_dn      = ~s2t_fract24[fract24_w-1];  // no hidden bit, subnormal
  assign s2t_00      = ~|s2t_fract24;

  always_comb begin
    s2t_word.f.sign = s1o_sign;
    s2t_word.f.exp  = s2t_dn ? '0 : s2t_exp10[exp_w-1:0];
    s2t_word.f.frac = s2t_fract24[frac_w-1:0];
    s2t_ine = s1o_lost;
    s2t_ovf = 1'b0;
    s2t_inf = 1'b0;
    s2t_unf = 1'b0;
    s2t_zer = 1'b0;
    if (s1o_snan | s1o_qnan) begin  // nan in, quiet nan out
      s2t_res = {s1o_anan_sign, f32_qnan};
      s2t_ine = 1'b0;
    end else if (s1o_inv) begin
      s2t_res = {s1o_sign, f32_snan};
      s2t_ine = 1'b0;
    end else if ((s2t_exp10 > 10'd254) | s1o_inf) begin
      s2t_res = {s1o_sign, f32_inf};
      s2t_ine = s1o_lost | ~s1o_inf;  // infinite operand is exact
      s2t_ovf = ~s1o_inf;
      s2t_inf = 1'b1;
    end else if (s2t_dn | s2t_00) begin
      s2t_res = s2t_word.bits;  // exp field already zero
      s2t_unf = s2t_00 & s1o_lost;
      s2t_zer = s2t_00;
    end else begin
      s2t_res = s2t_word.bits;
    end
  end

  // output register
  always_ff @(posedge clk) begin
    if (rst | flush_i) begin
      result_o <= '0;
      valid_o  <= 1'b0;
      flags_o  <= '0;
    end else if (adv_i) begin
      result_o         <= s2t_res;
      valid_o          <= s1o_ready;
      flags_o[flg_ovf] <= s2t_ovf;
      flags_o[flg_unf] <= s2t_unf;
      flags_o[flg_snf] <= s1o_inv;
      flags_o[flg_qnf] <= s1o_qnan;
      flags_o[flg_zf]  <= s2t_zer;
      flags_o[flg_ixf] <= s2t_ine;
      flags_o[flg_ivf] <= s1o_inv | s1o_snan;  // signaling input is invalid too
      flags_o[flg_inf] <= s2t_inf;
    end
  end

endmodule

//--- fpu_mul.sv
`timescale 1ns/1ps

module fpu_mul
  import fpu_types_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 adv_i,
  input  logic                 flush_i,
  input  logic                 start_i,
  input  logic [31:0]          a_i,
  input  logic [31:0]          b_i,
  output logic                 rdy_o,
  output logic                 sign_o,
  output logic [exp10_w-1:0]   exp10_o,
  output logic [fract24_w-1:0] fract24_o,
  output logic [1:0]           rs_o,
  output logic                 inv_o,        // 0 x inf
  output logic                 inf_o,
  output logic                 snan_o,
  output logic                 qnan_o,
  output logic                 anan_sign_o
);

  f32_word_u a_w, b_w;
  assign a_w.bits = a_i;
  assign b_w.bits = b_i;

  logic a_zero, b_zero, a_inf, b_inf, a_nan, b_nan;
  assign a_zero = ~|a_w.f.exp;  // subnormal in, zero used
  assign b_zero = ~|b_w.f.exp;
  assign a_inf  = (&a_w.f.exp) & ~|a_w.f.frac;
  assign b_inf  = (&b_w.f.exp) & ~|b_w.f.frac;
  assign a_nan  = (&a_w.f.exp) & |a_w.f.frac;
  assign b_nan  = (&b_w.f.exp) & |b_w.f.frac;

  //////////////////////////////
  // significand product

  logic [fract24_w-1:0] sig_a, sig_b;
  logic [47:0]          prod;
  assign sig_a = a_zero ? '0 : {1'b1, a_w.f.frac};
  assign sig_b = b_zero ? '0 : {1'b1, b_w.f.frac};
  assign prod  = sig_a * sig_b;  // 1.x * 1.x in [1, 4)

  // exponent sum, product carry folded in
  logic signed [exp10_w-1:0] exp_s;
  assign exp_s = $signed({2'b0, a_w.f.exp} + {2'b0, b_w.f.exp} + {9'd0, prod[47]}
                         - 10'(exp_bias));

  // one-bit normalize, low half folds into round and sticky
  logic [25:0] ext;
  assign ext = prod[47] ? {prod[47:24], prod[23], |prod[22:0]}
                        : {prod[46:23], prod[22], |prod[21:0]};

  //////////////////////////////
  // tiny results go subnormal at exponent 1

  logic               tiny;
  logic [exp10_w-1:0] dsh10;
  logic [4:0]         dsh;
  logic [52:0]        dn;
  assign tiny  = exp_s < 10'sd1;
  assign dsh10 = 10'd1 - $unsigned(exp_s);
  assign dsh   = (dsh10 > 10'd27) ? 5'd27 : dsh10[4:0];  // 27 clears all to sticky
  assign dn    = {ext, 27'd0} >> (tiny ? dsh : 5'd0);

  always_ff @(posedge clk) begin
    if (adv_i) begin
      sign_o      <= a_w.f.sign ^ b_w.f.sign;
      exp10_o     <= tiny ? 10'd1 : $unsigned(exp_s);
      fract24_o   <= dn[52:29];
      rs_o        <= {dn[28], |dn[27:0]};
      inv_o       <= (a_zero & b_inf) | (a_inf & b_zero);
      inf_o       <= a_inf | b_inf;
      snan_o      <= (a_nan & ~a_w.f.frac[frac_w-1]) | (b_nan & ~b_w.f.frac[frac_w-1]);
      qnan_o      <= (a_nan & a_w.f.frac[frac_w-1]) | (b_nan & b_w.f.frac[frac_w-1]);
      anan_sign_o <= a_nan ? a_w.f.sign : b_w.f.sign;
    end
  end

  always_ff @(posedge clk) begin
    if (rst | flush_i) begin
      rdy_o <= 1'b0;
    end else if (adv_i) begin
      rdy_o <= start_i;
    end
  end

endmodule

//--- fpu_addsub.sv
`timescale 1ns/1ps

module fpu_addsub
  import fpu_types_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 adv_i,        // advance pipe
  input  logic                 flush_i,      // drop valid
  input  logic                 start_i,      // one-cycle strobe
  input  logic                 sub_i,        // flip sign of b
  input  logic [31:0]          a_i,
  input  logic [31:0]          b_i,
  output logic                 rdy_o,
  output logic                 sign_o,
  output logic [exp10_w-1:0]   exp10_o,
  output logic [fract24_w-1:0] fract24_o,
  output logic [1:0]           rs_o,         // round, sticky
  output logic                 inv_o,        // inf - inf
  output logic                 inf_o,
  output logic                 snan_o,
  output logic                 qnan_o,
  output logic                 anan_sign_o
);

  // position of leading one counted from bit 26, 27 when empty
  function automatic logic [4:0] lzc27(input logic [26:0] v);
    logic [4:0] n;
    n = 5'd27;
    for (int i = 0; i < 27; i++) begin
      if (v[i]) n = 5'(26 - i);  // higher bits win
    end
    return n;
  endfunction

  //////////////////////////////
  // operand decode

  f32_word_u a_w, b_w;
  assign a_w.bits = a_i;
  assign b_w.bits = {b_i[31] ^ sub_i, b_i[30:0]};  // a - b == a + (-b)

  logic a_zero, b_zero, a_inf, b_inf, a_nan, b_nan;
  assign a_zero = ~|a_w.f.exp;  // subnormals read as zero
  assign b_zero = ~|b_w.f.exp;
  assign a_inf  = (&a_w.f.exp) & ~|a_w.f.frac;
  assign b_inf  = (&b_w.f.exp) & ~|b_w.f.frac;
  assign a_nan  = (&a_w.f.exp) & |a_w.f.frac;
  assign b_nan  = (&b_w.f.exp) & |b_w.f.frac;

  logic [fract24_w-1:0] sig_a, sig_b, sig_l, sig_s;
  assign sig_a = a_zero ? '0 : {1'b1, a_w.f.frac};
  assign sig_b = b_zero ? '0 : {1'b1, b_w.f.frac};

  // larger magnitude goes first
  logic      swap;
  f32_word_u l_w, s_w;
  assign swap  = b_w.bits[30:0] > a_w.bits[30:0];
  assign l_w   = swap ? b_w : a_w;
  assign s_w   = swap ? a_w : b_w;
  assign sig_l = swap ? sig_b : sig_a;
  assign sig_s = swap ? sig_a : sig_b;

  //////////////////////////////
  // align and add

  logic [exp_w-1:0] diff;
  logic [49:0]      s_ext;
  logic [26:0]      l_al, s_al;   // 24 bits + round + extra + sticky
  logic             eff_sub;
  logic [27:0]      sum;

  assign diff    = l_w.f.exp - s_w.f.exp;
  assign s_ext   = {sig_s, 26'd0} >> diff;
  // past 26 places everything lands in sticky
  assign s_al    = {s_ext[49:24], (diff > 8'd26) ? |sig_s : |s_ext[23:0]};
  assign l_al    = {sig_l, 3'b000};
  assign eff_sub = l_w.f.sign ^ s_w.f.sign;
  assign sum     = eff_sub ? {1'b0, l_al} - {1'b0, s_al}
                           : {1'b0, l_al} + {1'b0, s_al};

  //////////////////////////////
  // normalize

  logic               sum_zero;
  logic [4:0]         lz, lsh;
  logic [26:0]        norm;
  logic [exp10_w-1:0] exp_n;

  assign sum_zero = ~|sum;
  assign lz       = lzc27(sum[26:0]);
  // stop at exponent 1, what is left becomes a subnormal
  assign lsh      = ({3'd0, lz} < l_w.f.exp) ? lz : 5'(l_w.f.exp - 8'd1);

  always_comb begin
    if (sum[27]) begin  // carry out, one right shift
      norm  = {sum[27:2], sum[1] | sum[0]};
      exp_n = {2'b0, l_w.f.exp} + 10'd1;
    end else begin
      norm  = sum[26:0] << lsh;
      exp_n = sum_zero ? '0 : {2'b0, l_w.f.exp} - {5'd0, lsh};
    end
  end

  // payload, no reset
  always_ff @(posedge clk) begin
    if (adv_i) begin
      sign_o      <= (eff_sub & sum_zero) ? 1'b0 : l_w.f.sign;  // x - x is +0
      exp10_o     <= exp_n;
      fract24_o   <= norm[26:3];
      rs_o        <= {norm[2], |norm[1:0]};
      inv_o       <= a_inf & b_inf & eff_sub;
      inf_o       <= a_inf | b_inf;
      snan_o      <= (a_nan & ~a_w.f.frac[frac_w-1]) | (b_nan & ~b_w.f.frac[frac_w-1]);
      qnan_o      <= (a_nan & a_w.f.frac[frac_w-1]) | (b_nan & b_w.f.frac[frac_w-1]);
      anan_sign_o <= a_nan ? a_w.f.sign : b_w.f.sign;
    end
  end

  always_ff @(posedge clk) begin
    if (rst | flush_i) begin
      rdy_o <= 1'b0;
    end else if (adv_i) begin
      rdy_o <= start_i;
    end
  end

endmodule

//--- fpu_ctrl_pkg.sv
package fpu_ctrl_pkg;

  // operation select
  localparam logic [1:0] op_add = 2'd0;
  localparam logic [1:0] op_sub = 2'd1;
  localparam logic [1:0] op_mul = 2'd2;  // 2'd3 unused, nothing starts

  // rounding modes
  localparam logic [1:0] rm_nearest = 2'd0;  // ties to even
  localparam logic [1:0] rm_to_zero = 2'd1;
  localparam logic [1:0] rm_to_infp = 2'd2;
  localparam logic [1:0] rm_to_infm = 2'd3;

  // exception flag word
  localparam int flags_w = 8;
  localparam int flg_ovf = 0;  // overflow
  localparam int flg_unf = 1;  // underflow
  localparam int flg_snf = 2;  // snan produced
  localparam int flg_qnf = 3;  // qnan seen
  localparam int flg_zf  = 4;  // zero result
  localparam int flg_ixf = 5;  // inexact
  localparam int flg_ivf = 6;  // invalid
  localparam int flg_inf = 7;  // infinity result

endpackage

//--- fpu_types_pkg.sv
package fpu_types_pkg;

  // binary32 fields
  localparam int exp_w  = 8;   // stored exponent
  localparam int frac_w = 23;  // stored fraction, hidden bit dropped

  // internal unit -> rounding format
  localparam int exp10_w   = 10;  // room for overflow past 254
  localparam int fract24_w = 24;  // hidden bit at msb
  localparam int exp_bias  = 127;

  // result magnitudes, sign added when packed
  localparam logic [30:0] f32_inf  = 31'h7f80_0000;
  localparam logic [30:0] f32_qnan = 31'h7fc0_0000;
  localparam logic [30:0] f32_snan = 31'h7fbf_ffff;  // pattern for invalid ops

  // ieee field view of one word
  typedef struct packed {
    logic              sign;
    logic [exp_w-1:0]  exp;
    logic [frac_w-1:0] frac;
  } f32_fields_t;

  // same word as raw bits or as fields
  typedef union packed {
    logic [31:0] bits;
    f32_fields_t f;
  } f32_word_u;

endpackage
